//--- Bender.yml
package:
  name: vector_iir

sources:
  - include_dirs:
      - .
    files:
      - vector_iir_pkg.sv
      - vector_iir_regs.sv
      - vector_iir_delay_ram.sv
      - vector_iir_mac.sv
      - vector_iir.sv
      - vector_iir_block.sv
  - target: test
    files:
      - tb_vector_iir_block.sv

//--- all.f
+incdir+.
vector_iir_pkg.sv
vector_iir_regs.sv
vector_iir_delay_ram.sv
vector_iir_mac.sv
vector_iir.sv
vector_iir_block.sv
tb_vector_iir_block.sv

//--- tb_vector_iir_block.sv
// Testbench for the vector IIR block
// Replays a trace of settings writes and beats, checks output beats and latency

`timescale 1ns/1ps
`default_nettype none

module tb_vector_iir_block import vector_iir_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int LATENCY     = 3;
  localparam int SEG_TIMEOUT = 2000;

  logic         ce_clk;
  logic         i_rst;
  set_bus_t     set_bus;
  stream_beat_t s_beat;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t m_beat;
  logic         m_valid;
  logic         m_ready;

  integer       seed;
  string        test_name;
  logic         ready_random;
  int           cycle;

  // Pending beats of the current test
  logic [31:0]  in_data_q[$];
  int           in_gap_q[$];
  logic [32:0]  exp_q[$];
  // Edge count at which each input beat was taken
  int           in_cycle_q[$];

  initial ce_clk = 1'b0;
  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  vector_iir_block i_vector_iir_block (
    .ce_clk    (ce_clk),
    .i_rst     (i_rst),
    .i_set     (set_bus),
    .i_s_beat  (s_beat),
    .i_s_valid (s_valid),
    .o_s_ready (s_ready),
    .o_m_beat  (m_beat),
    .o_m_valid (m_valid),
    .i_m_ready (m_ready)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch %s: %s expected %0h actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  function automatic string trim_end(input string s);
    int k;
    k = s.len();
    while (k > 0 && (s[k-1] == "\n" || s[k-1] == "\r" || s[k-1] == " ")) begin
      k = k - 1;
    end
    return s.substr(0, k - 1);
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and stream drivers
  ////////////////////////////////////////////////////////////
  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(posedge ce_clk);
    set_bus <= '{stb: 1'b1, addr: addr, data: data};
    @(posedge ce_clk);
    set_bus.stb <= 1'b0;
    // Length-change pulse reaches the core here
    @(posedge ce_clk);
  endtask

  // Streams the queued beats and checks every output until both queues drain
  task automatic run_segment();
    int          waited;
    int          in_at;
    logic [32:0] exp_beat;
    logic [31:0] r;
    waited = 0;
    while (in_data_q.size() > 0 || exp_q.size() > 0) begin
      @(posedge ce_clk);
      cycle  = cycle + 1;
      waited = waited + 1;
      if (waited > SEG_TIMEOUT) begin
        abort_run($sformatf("timeout in %s: the output stream stopped delivering beats",
                            test_name));
      end
      // A held output beat blocks the input side
      if (m_valid && !m_ready) begin
        check_value("input ready under stall", 1'b0, s_ready);
      end
      // Output side
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          abort_run($sformatf("%s: output beat arrived with nothing expected", test_name));
        end
        exp_beat = exp_q.pop_front();
        check_value("output beat", exp_beat, m_beat);
        in_at = in_cycle_q.pop_front();
        if (!ready_random) begin
          check_value("latency", LATENCY, cycle - in_at);
        end
      end
      // Input side
      if (s_valid && s_ready) begin
        in_cycle_q.push_back(cycle);
        in_data_q.delete(0);
        in_gap_q.delete(0);
      end
      if (in_data_q.size() > 0 && in_gap_q[0] == 0) begin
        s_beat  <= {in_data_q[0], 1'b0};
        s_valid <= 1'b1;
      end else begin
        s_valid <= 1'b0;
        if (in_data_q.size() > 0) begin
          in_gap_q[0] = in_gap_q[0] - 1;
        end
      end
      if (ready_random) begin
        r = $random(seed);
        m_ready <= r[0];
      end else begin
        m_ready <= 1'b1;
      end
    end
    // Pipeline must now be empty
    m_ready <= 1'b1;
    repeat (LATENCY + 1) begin
      @(posedge ce_clk);
      cycle = cycle + 1;
      if (m_valid) begin
        abort_run($sformatf("%s: extra output beat after the last expected one", test_name));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Trace replay
  ////////////////////////////////////////////////////////////
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] word_a;
    logic [31:0] word_b;
    int          gap;
    int          exp_last;
    seed         = 99;
    i_rst        = 1'b1;
    set_bus      = '0;
    s_beat       = '0;
    s_valid      = 1'b0;
    m_ready      = 1'b0;
    ready_random = 1'b0;
    cycle        = 0;
    test_name    = "reset";
    fd = $fopen("vector_iir_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file vector_iir_trace.txt");
    end
    repeat (2) @(posedge ce_clk);
    i_rst <= 1'b0;
    check_value("output valid after reset", 1'b0, m_valid);
    check_value("input ready after reset", 1'b1, s_ready);

    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      line = trim_end(line);
      if (n == 0 || line.len() == 0 || line[0] == "#") begin
        continue;
      end
      case (line[0])
        "T": begin
          run_segment();
          ready_random = (line[2] == "1");
          test_name    = line.substr(4, line.len() - 1);
        end
        "W": begin
          run_segment();
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h", word_a, word_b);
          if (n != 2) begin
            abort_run($sformatf("malformed settings line in trace: %s", line));
          end
          write_setting(word_a[7:0], word_b);
        end
        "B": begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %d %h %d",
                      word_a, gap, word_b, exp_last);
          if (n != 4) begin
            abort_run($sformatf("malformed beat line in trace: %s", line));
          end
          in_data_q.push_back(word_a);
          in_gap_q.push_back(gap);
          exp_q.push_back({word_b, exp_last[0]});
        end
        default: begin
          abort_run($sformatf("unknown line in trace: %s", line));
        end
      endcase
    end
    run_segment();
    $fclose(fd);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vector_iir.sv
// Vector IIR core
// Element indexing, history tracking and a stallable three-stage pipeline

`timescale 1ns/1ps
`default_nettype none

`include "vector_iir_macros.svh"

module vector_iir import vector_iir_pkg::*; (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst,
  input  wire logic [`MAX_LOG2_OF_SIZE:0] i_vector_len,
  input  wire logic signed [15:0]         i_alpha,
  input  wire logic signed [15:0]         i_beta,
  input  wire logic                       i_len_change,
  input  wire stream_beat_t               i_s_beat,
  input  wire logic                       i_s_valid,
  output logic                            o_s_ready,
  output stream_beat_t                    o_m_beat,
  output logic                            o_m_valid,
  input  wire logic                       i_m_ready
);

  localparam int AW = `MAX_LOG2_OF_SIZE;

  logic        advance;
  logic        accept;
  core_state_t state;
  logic [AW-1:0] idx;
  logic        idx_at_end;

  // Per-stage control travelling with each beat
  logic          s0_valid;
  logic          s0_first;
  logic          s0_last;
  logic [AW-1:0] s0_idx;
  iir_sample_t   s0_x;
  logic          s1_valid;
  logic          s1_last;
  logic [AW-1:0] s1_idx;
  logic          s2_last;
  logic [AW-1:0] s2_idx;
  logic          wb_pend;

  iir_sample_t prev_sample;
  iir_sample_t mac_y;

  // Whole pipeline moves only when the output slot frees up
  assign advance    = ~o_m_valid | i_m_ready;
  assign o_s_ready  = advance;
  assign accept     = i_s_valid & advance;
  assign idx_at_end = ({1'b0, idx} == i_vector_len - 1'b1);

  ////////////////////////////////////////////////////////////
  // Element index and history state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst || i_len_change) begin
      idx   <= '0;
      state <= FIRST_PASS;
    end else if (accept) begin
      if (idx_at_end) begin
        idx   <= '0;
        state <= RUNNING;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Valid pipeline
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s0_valid  <= 1'b0;
      s1_valid  <= 1'b0;
      o_m_valid <= 1'b0;
      wb_pend   <= 1'b0;
    end else begin
      if (advance) begin
        s0_valid  <= i_s_valid;
        s1_valid  <= s0_valid;
        o_m_valid <= s1_valid;
      end
      // Write-back the cycle after a result lands in the output register
      wb_pend <= advance & s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      s0_x     <= i_s_beat.data;
      s0_idx   <= idx;
      s0_first <= (state == FIRST_PASS);
      s0_last  <= idx_at_end;
    end
    if (advance) begin
      s1_idx  <= s0_idx;
      s1_last <= s0_last;
      s2_idx  <= s1_idx;
      s2_last <= s1_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // History memory and arithmetic
  ////////////////////////////////////////////////////////////
  vector_iir_delay_ram inst_delay_ram (
    .i_clk     (i_clk),
    .i_wr_en   (wb_pend),
    .i_wr_addr (s2_idx),
    .i_wr_data (mac_y),
    .i_rd_en   (accept),
    .i_rd_addr (idx),
    .o_rd_data (prev_sample)
  );

  vector_iir_mac inst_mac (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_advance   (advance),
    .i_alpha     (i_alpha),
    .i_beta      (i_beta),
    .i_prev      (prev_sample),
    .i_x         (s0_x),
    .i_zero_prev (s0_first),
    .o_y         (mac_y)
  );

  assign o_m_beat = '{data: mac_y, last: s2_last};

  // Held beat must not change until the sink takes it
  a_out_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_beat))
    else $error("output beat changed while stalled");

  // Min length keeps the write-back one cycle ahead of the next read
  a_no_rw_clash: assert property (@(posedge i_clk) disable iff (i_rst)
    !(wb_pend && accept && (s2_idx == idx)))
    else $error("delay memory read and write hit the same element");

endmodule

`default_nettype wire

//--- vector_iir_block.sv
// Vector IIR processing block
// Settings registers feeding the streaming IIR core

`timescale 1ns/1ps
`default_nettype none

`include "vector_iir_macros.svh"

module vector_iir_block import vector_iir_pkg::*; (
  input  wire logic         ce_clk,
  input  wire logic         i_rst,

  // Settings bus
  input  wire set_bus_t     i_set,

  // Input stream
  input  wire stream_beat_t i_s_beat,
  input  wire logic         i_s_valid,
  output logic              o_s_ready,

  // Output stream
  output stream_beat_t      o_m_beat,
  output logic              o_m_valid,
  input  wire logic         i_m_ready
);

  logic [`MAX_LOG2_OF_SIZE:0] vector_len;
  logic signed [15:0]         alpha;
  logic signed [15:0]         beta;
  logic                       len_change;

  ////////////////////////////////////////////////////////////
  // Settings
  ////////////////////////////////////////////////////////////
  vector_iir_regs inst_vector_iir_regs (
    .i_clk        (ce_clk),
    .i_rst        (i_rst),
    .i_set        (i_set),
    .o_vector_len (vector_len),
    .o_alpha      (alpha),
    .o_beta       (beta),
    .o_len_change (len_change)
  );

  ////////////////////////////////////////////////////////////
  // Core
  ////////////////////////////////////////////////////////////
  vector_iir inst_vector_iir (
    .i_clk        (ce_clk),
    .i_rst        (i_rst),
    .i_vector_len (vector_len),
    .i_alpha      (alpha),
    .i_beta       (beta),
    .i_len_change (len_change),
    .i_s_beat     (i_s_beat),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .o_m_beat     (o_m_beat),
    .o_m_valid    (o_m_valid),
    .i_m_ready    (i_m_ready)
  );

endmodule

`default_nettype wire

//--- vector_iir_delay_ram.sv
// Vector IIR delay memory
// Dual-port store of the previous output for every vector element

`timescale 1ns/1ps
`default_nettype none

`include "vector_iir_macros.svh"

module vector_iir_delay_ram import vector_iir_pkg::*; (
  input  wire logic                          i_clk,

  // Write port
  input  wire logic                          i_wr_en,
  input  wire logic [`MAX_LOG2_OF_SIZE-1:0]  i_wr_addr,
  input  wire iir_sample_t                   i_wr_data,

  // Read port, data one cycle after the enable
  input  wire logic                          i_rd_en,
  input  wire logic [`MAX_LOG2_OF_SIZE-1:0]  i_rd_addr,
  output iir_sample_t                        o_rd_data
);

  localparam int DEPTH = `MAX_VECTOR_LEN;

  iir_sample_t mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Holds the last word while idle so a stalled pipeline keeps it
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- vector_iir_mac.sv
// Vector IIR multiply-accumulate
// alpha * prev + beta * x per component, rounded, shifted by 15 and saturated

`timescale 1ns/1ps
`default_nettype none

module vector_iir_mac import vector_iir_pkg::*; (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_advance,
  input  wire logic signed [15:0] i_alpha,
  input  wire logic signed [15:0] i_beta,
  input  wire iir_sample_t        i_prev,
  input  wire iir_sample_t        i_x,
  input  wire logic               i_zero_prev,
  output iir_sample_t             o_y
);

  // Add half an LSB, drop 15 fraction bits, clamp to 16 bits
  function automatic logic signed [15:0] round_sat(
    input logic signed [31:0] fb,
    input logic signed [31:0] ff
  );
    logic signed [33:0] sum;
    logic signed [18:0] shifted;
    sum     = fb + ff + 34'sd16384;
    shifted = sum[33:15];
    if (shifted > 19'sd32767) begin
      return 16'sh7fff;
    end else if (shifted < -19'sd32768) begin
      return 16'sh8000;
    end
    return shifted[15:0];
  endfunction

  logic signed [15:0] prev_i;
  logic signed [15:0] prev_q;
  // Feedback and feed-forward products
  logic signed [31:0] fb_i;
  logic signed [31:0] fb_q;
  logic signed [31:0] ff_i;
  logic signed [31:0] ff_q;
  iir_sample_t        y_next;

  // No history on the first vector
  assign prev_i = i_zero_prev ? 16'sd0 : i_prev.i;
  assign prev_q = i_zero_prev ? 16'sd0 : i_prev.q;

  ////////////////////////////////////////////////////////////
  // Stage 1 products
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_advance) begin
      fb_i <= i_alpha * prev_i;
      fb_q <= i_alpha * prev_q;
      ff_i <= i_beta * i_x.i;
      ff_q <= i_beta * i_x.q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 sum into the output register
  ////////////////////////////////////////////////////////////
  assign y_next.i = round_sat(fb_i, ff_i);
  assign y_next.q = round_sat(fb_q, ff_q);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_y <= '0;
    end else if (i_advance) begin
      o_y <= y_next;
    end
  end

endmodule

`default_nettype wire

//--- vector_iir_macros.svh
// Vector IIR shared constants
// Settings register addresses, vector size limits and reset defaults

`ifndef VECTOR_IIR_MACROS_SVH
`define VECTOR_IIR_MACROS_SVH

////////////////////////////////////////////////////////////
// Settings bus addresses
////////////////////////////////////////////////////////////
`define SR_VECTOR_LEN 8'd129
`define SR_ALPHA 8'd130
`define SR_BETA 8'd131

////////////////////////////////////////////////////////////
// Vector size limits
////////////////////////////////////////////////////////////
// Delay memory address width
`define MAX_LOG2_OF_SIZE 11
`define MAX_VECTOR_LEN (1 << `MAX_LOG2_OF_SIZE)
// Keeps a write-back ahead of the next read of the same element
`define MIN_VECTOR_LEN 4

////////////////////////////////////////////////////////////
// Reset defaults
////////////////////////////////////////////////////////////
`define DEFAULT_VECTOR_LEN 16
`define DEFAULT_ALPHA 0
// Just under 1.0 in Q1.15
`define DEFAULT_BETA 32767

`endif

//--- vector_iir_pkg.sv
// Vector IIR types
// Sample, stream beat and settings bus structs plus the core state encoding

`default_nettype none

package vector_iir_pkg;

  ////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////

  // One complex sample, I in the upper half of the beat
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iir_sample_t;

  // Stream beat with end-of-vector flag
  typedef struct packed {
    iir_sample_t data;
    logic        last;
  } stream_beat_t;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  // Single-cycle strobed register write
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // First vector uses zero history, later ones the stored outputs
  typedef enum logic {
    FIRST_PASS = 1'b0,
    RUNNING    = 1'b1
  } core_state_t;

endpackage

`default_nettype wire

//--- vector_iir_regs.sv
// Vector IIR settings registers
// Decodes strobed writes into vector length, alpha and beta

`timescale 1ns/1ps
`default_nettype none

`include "vector_iir_macros.svh"

module vector_iir_regs import vector_iir_pkg::*; (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst,
  input  wire set_bus_t                   i_set,
  output logic [`MAX_LOG2_OF_SIZE:0]      o_vector_len,
  output logic signed [15:0]              o_alpha,
  output logic signed [15:0]              o_beta,
  output logic                            o_len_change
);

  localparam logic [15:0] LEN_MIN = 16'(`MIN_VECTOR_LEN);
  localparam logic [15:0] LEN_MAX = 16'(`MAX_VECTOR_LEN);

  logic [`MAX_LOG2_OF_SIZE:0] len_clamped;

  // Pull the requested length into the supported range
  always_comb begin
    if (i_set.data[15:0] < LEN_MIN) begin
      len_clamped = LEN_MIN[`MAX_LOG2_OF_SIZE:0];
    end else if (i_set.data[15:0] > LEN_MAX) begin
      len_clamped = LEN_MAX[`MAX_LOG2_OF_SIZE:0];
    end else begin
      len_clamped = i_set.data[`MAX_LOG2_OF_SIZE:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_vector_len <= (`MAX_LOG2_OF_SIZE + 1)'(`DEFAULT_VECTOR_LEN);
      o_alpha      <= 16'(`DEFAULT_ALPHA);
      o_beta       <= 16'(`DEFAULT_BETA);
      o_len_change <= 1'b0;
    end else begin
      o_len_change <= 1'b0;
      if (i_set.stb) begin
        case (i_set.addr)
          `SR_VECTOR_LEN: begin
            o_vector_len <= len_clamped;
            // Core restarts its index and history on this
            o_len_change <= 1'b1;
          end
          `SR_ALPHA: o_alpha <= i_set.data[15:0];
          `SR_BETA:  o_beta  <= i_set.data[15:0];
          default: ;
        endcase
      end
    end
  end

  // Length must stay usable by the core's index and memory
  a_len_range: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_vector_len >= LEN_MIN[`MAX_LOG2_OF_SIZE:0]) &&
    (o_vector_len <= LEN_MAX[`MAX_LOG2_OF_SIZE:0]))
    else $error("vector length out of range");

endmodule

`default_nettype wire

//--- vector_iir_trace.txt
# T <ready mode, 0 held high, 1 random> <test name>   W <addr hex> <data hex>
# B <input IIIIQQQQ hex> <idle gap> <expected IIIIQQQQ hex> <expected last>
T 0 reset_defaults
B 0001FFFF 0 0001FFFF 0
B 4000C000 0 4000C001 0
B 7FFF8000 0 7FFE8001 0
B 1234EDCC 0 1234EDCC 0
B 4001BFFF 3 4000C000 0
B 00000000 0 00000000 0
B 6000A000 0 5FFFA001 0
B 0100FF00 0 0100FF00 0
B 3FFFC001 6 3FFFC001 0
B 70009000 0 6FFF9001 0
B 0ABCF544 0 0ABCF544 0
B 5555AAAA 0 5554AAAB 0
B 00100020 2 00100020 0
B 7FFE8001 0 7FFD8002 0
B 2000E000 0 2000E000 0
B 4567BA98 0 4566BA99 1
T 1 recursion
W 82 00004000
W 81 00000004
B 1000F000 0 1000F000 0
B 7FFF8000 0 7FFE8001 0
B 00004000 0 00004000 0
B 0123FEDD 0 0123FEDD 1
B 1000F000 0 1800E800 0
B 00000000 1 3FFFC001 0
B 20002000 0 20004000 0
B 0123FEDD 0 01B4FE4C 1
T 1 saturation_and_length_clamp
W 82 00007FFF
W 81 00000002
B 7FFF8000 0 7FFE8001 0
B 4000C000 0 4000C001 0
B 00000000 0 00000000 0
B 70009000 0 6FFF9001 1
B 7FFF8000 0 7FFF8000 0
B 4000C000 0 7FFF8002 0
B 7FFF8000 2 7FFE8001 0
B 70009000 0 7FFF8000 1
